/* tb.f */
+incdir+hdl
+incdir+test
hdl/fp_format_pkg.sv
hdl/fp_add_stage_pkg.sv
hdl/fp_add_unpack.sv
hdl/fp_add_align_sum.sv
hdl/fp_add_normalize.sv
hdl/fp_add_round.sv
hdl/fp_add_top.sv
test/fp_add_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the adder testbench with Verilator, run it, judge the log

verilator --binary --timing --top-module fp_add_tb -f tb.f -o fp_add_sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/fp_add_sim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation exited abnormally"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation reported failures"; exit 1; }
echo "Simulation passed"
exit 0

/* test/fp_add_vectors.svh */
`ifndef FP_ADD_VECTORS_SVH
`define FP_ADD_VECTORS_SVH

  // Columns: operand a, operand b, subtract, rounding mode,
  // expected result, expected flags as {nv, dz, of, uf, nx}

  task automatic load_vectors();
    // 1.0 + 2.0 is exact in every mode
    append_vector(32'h3F800000, 32'h40000000, 1'b0, FRM_RNE, 32'h40400000, 5'b00000);
    append_vector(32'h3F800000, 32'h40000000, 1'b0, FRM_RTZ, 32'h40400000, 5'b00000);
    append_vector(32'h3F800000, 32'h40000000, 1'b0, FRM_RDN, 32'h40400000, 5'b00000);
    append_vector(32'h3F800000, 32'h40000000, 1'b0, FRM_RUP, 32'h40400000, 5'b00000);
    append_vector(32'h3F800000, 32'h40000000, 1'b0, FRM_RMM, 32'h40400000, 5'b00000);
    // 3.0 - 1.0 is exact in every mode
    append_vector(32'h40400000, 32'h3F800000, 1'b1, FRM_RNE, 32'h40000000, 5'b00000);
    append_vector(32'h40400000, 32'h3F800000, 1'b1, FRM_RTZ, 32'h40000000, 5'b00000);
    append_vector(32'h40400000, 32'h3F800000, 1'b1, FRM_RDN, 32'h40000000, 5'b00000);
    append_vector(32'h40400000, 32'h3F800000, 1'b1, FRM_RUP, 32'h40000000, 5'b00000);
    append_vector(32'h40400000, 32'h3F800000, 1'b1, FRM_RMM, 32'h40000000, 5'b00000);

    // 3.0 - 3.0 cancels, negative zero only when rounding down
    append_vector(32'h40400000, 32'h40400000, 1'b1, FRM_RNE, 32'h00000000, 5'b00000);
    append_vector(32'h40400000, 32'h40400000, 1'b1, FRM_RTZ, 32'h00000000, 5'b00000);
    append_vector(32'h40400000, 32'h40400000, 1'b1, FRM_RDN, 32'h80000000, 5'b00000);
    append_vector(32'h40400000, 32'h40400000, 1'b1, FRM_RUP, 32'h00000000, 5'b00000);
    append_vector(32'h40400000, 32'h40400000, 1'b1, FRM_RMM, 32'h00000000, 5'b00000);
    // Two negative zeros keep their common sign
    append_vector(32'h80000000, 32'h80000000, 1'b0, FRM_RNE, 32'h80000000, 5'b00000);

    // 1.0 + 2^-24 is a tie between 1.0 and the next value up
    append_vector(32'h3F800000, 32'h33800000, 1'b0, FRM_RNE, 32'h3F800000, 5'b00001);
    append_vector(32'h3F800000, 32'h33800000, 1'b0, FRM_RTZ, 32'h3F800000, 5'b00001);
    append_vector(32'h3F800000, 32'h33800000, 1'b0, FRM_RDN, 32'h3F800000, 5'b00001);
    append_vector(32'h3F800000, 32'h33800000, 1'b0, FRM_RUP, 32'h3F800001, 5'b00001);
    append_vector(32'h3F800000, 32'h33800000, 1'b0, FRM_RMM, 32'h3F800001, 5'b00001);
    // Negative mirror, down and up swap roles
    append_vector(32'hBF800000, 32'hB3800000, 1'b0, FRM_RDN, 32'hBF800001, 5'b00001);
    append_vector(32'hBF800000, 32'hB3800000, 1'b0, FRM_RUP, 32'hBF800000, 5'b00001);

    // Quiet NaN passes silently, signalling NaN raises nv
    append_vector(32'h7FC00000, 32'h3F800000, 1'b0, FRM_RNE, 32'h7FC00000, 5'b00000);
    append_vector(32'h7F800001, 32'h3F800000, 1'b0, FRM_RNE, 32'h7FC00000, 5'b10000);
    // inf - inf is invalid
    append_vector(32'h7F800000, 32'h7F800000, 1'b1, FRM_RNE, 32'h7FC00000, 5'b10000);
    // A lone infinity wins over a finite operand
    append_vector(32'h7F800000, 32'h3F800000, 1'b0, FRM_RNE, 32'h7F800000, 5'b00000);

    // Largest finite doubled overflows, saturating only under RTZ
    append_vector(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, FRM_RNE, 32'h7F800000, 5'b00101);
    append_vector(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, FRM_RTZ, 32'h7F7FFFFF, 5'b00101);
    // Difference of 2^-149 is below the normal range and flushes
    append_vector(32'h00800001, 32'h00800000, 1'b1, FRM_RNE, 32'h00000000, 5'b00011);
  endtask

`endif

/* test/fp_add_tb.sv */
`default_nettype none

`include "fp_add_defines.svh"

module fp_add_tb
  import fp_format_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 4;
  // Margin past the table length before the watchdog gives up
  localparam int SLACK_CYCLES = 20;

  // One row of the stimulus table
  typedef struct packed {
    fp_word_t  a;
    fp_word_t  b;
    logic      sub;
    fp_rm_e    rm;
    fp_word_t  exp_result;
    fp_flags_t exp_flags;
  } vector_t;

  logic      clk;
  logic      rst;
  logic      in_valid;
  fp_word_t  operand_a;
  fp_word_t  operand_b;
  logic      is_subtract;
  fp_rm_e    rounding_mode;
  logic      out_valid;
  fp_word_t  out_result;
  fp_flags_t out_flags;

  vector_t vectors[$];
  // Free-running count of rising edges
  int      cycle;
  int      first_issue_cycle;
  int      last_result_cycle;
  int      result_count;
  int      error_count;
  int      tests_passed;
  int      tests_failed;

  fp_add_top i_fp_add_top (
    .i_clk           (clk),
    .i_rst           (rst),
    .i_valid         (in_valid),
    .i_operand_a     (operand_a),
    .i_operand_b     (operand_b),
    .i_is_subtract   (is_subtract),
    .i_rounding_mode (rounding_mode),
    .o_valid         (out_valid),
    .o_result        (out_result),
    .o_flags         (out_flags)
  );

  // ==========================================================================
  // Clock, cycle count and helpers
  // ==========================================================================

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      error_count = error_count + 1;
    end
  endtask

  task automatic append_vector(input fp_word_t a, input fp_word_t b, input logic sub,
                               input fp_rm_e rm, input fp_word_t result,
                               input fp_flags_t flags);
    vector_t v;
    v.a          = a;
    v.b          = b;
    v.sub        = sub;
    v.rm         = rm;
    v.exp_result = result;
    v.exp_flags  = flags;
    vectors.push_back(v);
  endtask

  `include "fp_add_vectors.svh"

  // ==========================================================================
  // Stimulus, the whole table back to back
  // ==========================================================================

  initial begin : stimulus
    rst               = 1'b1;
    // Strobe held high through reset, the pipeline must still stay empty
    in_valid          = 1'b1;
    operand_a         = '0;
    operand_b         = '0;
    is_subtract       = 1'b0;
    rounding_mode     = FRM_RNE;
    cycle             = 0;
    first_issue_cycle = -1;
    last_result_cycle = 0;
    result_count      = 0;
    error_count       = 0;
    tests_passed      = 0;
    tests_failed      = 0;
    load_vectors();

    repeat (RESET_CYCLES) @(posedge clk);
    rst      <= 1'b0;
    in_valid <= 1'b0;

    // i_valid held high for every row in turn
    foreach (vectors[i]) begin
      @(posedge clk);
      in_valid      <= 1'b1;
      operand_a     <= vectors[i].a;
      operand_b     <= vectors[i].b;
      is_subtract   <= vectors[i].sub;
      rounding_mode <= vectors[i].rm;
    end
    @(posedge clk);
    in_valid <= 1'b0;
  end

  // ==========================================================================
  // Collector, sampled on the falling edge
  // ==========================================================================

  initial begin : collector
    vector_t exp_v;
    int      errors_before;

    // No strobe may leave the pipeline during reset
    @(negedge clk);
    while (rst) begin
      check_value("o_valid", 32'd0, 32'(out_valid));
      @(negedge clk);
    end

    while (result_count < vectors.size()) begin
      @(negedge clk);
      if (in_valid && first_issue_cycle < 0) begin
        first_issue_cycle = cycle;
      end
      if (out_valid) begin
        exp_v         = vectors[result_count];
        errors_before = error_count;
        // First result after the fixed latency, the rest on back-to-back cycles
        if (result_count == 0) begin
          check_value("o_valid latency", `FP_ADD_LATENCY, cycle - first_issue_cycle);
        end else begin
          check_value("o_valid spacing", 32'd1, cycle - last_result_cycle);
        end
        last_result_cycle = cycle;
        check_value("o_result", exp_v.exp_result, out_result);
        check_value("o_flags", 32'(exp_v.exp_flags), 32'(out_flags));
        $display("test %0d: %h %s %h rm=%0d -> %h flags=%b : %s", result_count,
                 exp_v.a, exp_v.sub ? "-" : "+", exp_v.b, exp_v.rm, out_result, out_flags,
                 (error_count == errors_before) ? "ok" : "mismatch");
        if (error_count == errors_before) begin
          tests_passed = tests_passed + 1;
        end else begin
          tests_failed = tests_failed + 1;
        end
        result_count = result_count + 1;
      end
    end

    // Pipeline must go quiet once the table is drained
    repeat (3) begin
      @(negedge clk);
      check_value("o_valid", 32'd0, 32'(out_valid));
    end

    $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // ==========================================================================
  // Watchdog
  // ==========================================================================

  initial begin : watchdog
    // Let the table load before sizing the limit
    #1;
    #((RESET_CYCLES + vectors.size() + SLACK_CYCLES) * CLK_PERIOD);
    $display("Timeout: only %0d of %0d results came back, the rest went missing",
             result_count, vectors.size());
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/fp_add_top.sv */
`default_nettype none

module fp_add_top
  import fp_format_pkg::*;
  import fp_add_stage_pkg::*;
(
  input  wire logic     i_clk,
  input  wire logic     i_rst,
  input  wire logic     i_valid,
  input  wire fp_word_t i_operand_a,
  input  wire fp_word_t i_operand_b,
  input  wire logic     i_is_subtract,
  input  wire fp_rm_e   i_rounding_mode,
  output logic          o_valid,
  output fp_word_t      o_result,
  output fp_flags_t     o_flags
);

  // ========================================================================
  // Four-stage chain, one operation per cycle
  // ========================================================================

  logic       s1_valid, s2_valid, s3_valid;
  align_rec_t s1_rec;
  sum_rec_t   s2_rec;
  norm_rec_t  s3_rec;

  // Classify, order by magnitude, find the shift
  fp_add_unpack u_unpack (
    .i_clk, .i_rst, .i_valid, .i_operand_a, .i_operand_b,
    .i_is_subtract, .i_rounding_mode,
    .o_valid (s1_valid),
    .o_rec   (s1_rec)
  );

  // Align and add magnitudes
  fp_add_align_sum u_align_sum (
    .i_clk, .i_rst,
    .i_valid (s1_valid),
    .i_rec   (s1_rec),
    .o_valid (s2_valid),
    .o_rec   (s2_rec)
  );

  fp_add_normalize u_normalize (
    .i_clk, .i_rst,
    .i_valid (s2_valid),
    .i_rec   (s2_rec),
    .o_valid (s3_valid),
    .o_rec   (s3_rec)
  );

  // Round, pack and flag
  fp_add_round u_round (
    .i_clk, .i_rst,
    .i_valid (s3_valid),
    .i_rec   (s3_rec),
    .o_valid, .o_result, .o_flags
  );

endmodule

`default_nettype wire

/* hdl/fp_add_round.sv */
`default_nettype none

`include "fp_add_defines.svh"

module fp_add_round
  import fp_format_pkg::*;
  import fp_add_stage_pkg::*;
(
  input  wire logic      i_clk,
  input  wire logic      i_rst,
  input  wire logic      i_valid,
  input  wire norm_rec_t i_rec,
  output logic           o_valid,
  output fp_word_t       o_result,
  output fp_flags_t      o_flags
);

  logic [`FP_MANT_W-1:0]        mant;
  logic                         guard_bit, round_bit, sticky_bit;
  logic                         inexact, round_up, carry, zero_sign;
  logic [`FP_MANT_W:0]          rounded;
  logic [`FP_FRAC_W-1:0]        frac;
  logic signed [`FP_EXPX_W-1:0] exp_adj;
  fp_word_t                     result_next;
  fp_flags_t                    flags_next;

  // ========================================================================
  // Rounding bits and round-up decision
  // ========================================================================

  // Hidden bit at FP_SUM_W-2, guard and round right below the kept mantissa
  assign mant       = i_rec.norm_sum[`FP_SUM_W-2 -: `FP_MANT_W];
  assign guard_bit  = i_rec.norm_sum[`FP_SUM_W-`FP_MANT_W-2];
  assign round_bit  = i_rec.norm_sum[`FP_SUM_W-`FP_MANT_W-3];
  assign sticky_bit = (|i_rec.norm_sum[`FP_SUM_W-`FP_MANT_W-4:0]) | i_rec.overflow_guard
                    | i_rec.sticky;
  assign inexact    = guard_bit | round_bit | sticky_bit;

  always_comb begin
    case (i_rec.rm)
      FRM_RTZ: round_up = 1'b0;
      FRM_RDN: round_up = i_rec.result_sign & inexact;
      FRM_RUP: round_up = ~i_rec.result_sign & inexact;
      FRM_RMM: round_up = guard_bit;
      // Nearest, ties to even, also covers reserved codes
      default: round_up = guard_bit & (round_bit | sticky_bit | mant[0]);
    endcase
  end

  // Increment may ripple into a new leading bit
  assign rounded = {1'b0, mant} + {{`FP_MANT_W{1'b0}}, round_up};
  assign carry   = rounded[`FP_MANT_W];
  assign frac    = carry ? rounded[`FP_MANT_W-1:1] : rounded[`FP_FRAC_W-1:0];
  assign exp_adj = carry ? (i_rec.exp + 10'sd1) : i_rec.exp;
  // Exact zero takes the common sign, else minus only when rounding down
  assign zero_sign = i_rec.both_signs_equal ? i_rec.result_sign : (i_rec.rm == FRM_RDN);

  // ========================================================================
  // Result selection
  // ========================================================================

  always_comb begin
    result_next = '0;
    flags_next  = '0;
    if (i_rec.special.valid) begin
      result_next   = i_rec.special.result;
      flags_next.nv = i_rec.special.invalid;
    end else if (i_rec.sum_is_zero && !i_rec.sticky) begin
      result_next = {zero_sign, {(`FP_EXP_W+`FP_FRAC_W){1'b0}}};
    end else if (exp_adj >= $signed({2'b00, `FP_EXP_MAX})) begin
      flags_next.of = 1'b1;
      flags_next.nx = 1'b1;
      // Saturate to the largest finite value when rounding toward it
      if ((i_rec.rm == FRM_RTZ) || (i_rec.rm == FRM_RDN && !i_rec.result_sign) ||
          (i_rec.rm == FRM_RUP && i_rec.result_sign)) begin
        result_next = {i_rec.result_sign, `FP_EXP_MAX - 8'd1, {`FP_FRAC_W{1'b1}}};
      end else begin
        result_next = {i_rec.result_sign, `FP_EXP_MAX, {`FP_FRAC_W{1'b0}}};
      end
    end else if (exp_adj <= 10'sd0) begin
      // Too small for a normal, flush to signed zero
      result_next   = {i_rec.result_sign, {(`FP_EXP_W+`FP_FRAC_W){1'b0}}};
      flags_next.uf = 1'b1;
      flags_next.nx = 1'b1;
    end else begin
      result_next   = {i_rec.result_sign, exp_adj[`FP_EXP_W-1:0], frac};
      flags_next.nx = inexact;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid  <= 1'b0;
      o_result <= '0;
      o_flags  <= '0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_result <= result_next;
        o_flags  <= flags_next;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/fp_add_normalize.sv */
`default_nettype none

`include "fp_add_defines.svh"

module fp_add_normalize
  import fp_add_stage_pkg::*;
(
  input  wire logic     i_clk,
  input  wire logic     i_rst,
  input  wire logic     i_valid,
  input  wire sum_rec_t i_rec,
  output logic          o_valid,
  output norm_rec_t     o_rec
);

  logic [`FP_LZC_W-1:0]         lzc;
  logic                         found;
  logic                         sum_is_zero;
  logic [`FP_LZC_W-1:0]         norm_shift;
  logic signed [`FP_EXPX_W-1:0] exp_in;
  norm_rec_t                    rec_next;

  // ========================================================================
  // Leading-zero count
  // ========================================================================

  // Priority scan from the carry bit down
  always_comb begin
    lzc   = '0;
    found = 1'b0;
    for (int i = `FP_SUM_W - 1; i >= 0; i--) begin
      if (!found) begin
        if (i_rec.sum[i]) begin
          found = 1'b1;
        end else begin
          lzc = lzc + 1'b1;
        end
      end
    end
  end

  assign sum_is_zero = (i_rec.sum == '0);
  assign exp_in      = $signed(i_rec.exp);
  // One leading zero is the normal position, hidden bit under the carry
  assign norm_shift  = (lzc > 1) ? (lzc - 1'b1) : '0;

  // ========================================================================
  // Shift toward the hidden-bit position
  // ========================================================================

  always_comb begin
    rec_next.result_sign      = i_rec.result_sign;
    rec_next.both_signs_equal = i_rec.both_signs_equal;
    rec_next.sum_is_zero      = sum_is_zero;
    rec_next.sticky           = i_rec.sticky;
    rec_next.special          = i_rec.special;
    rec_next.rm               = i_rec.rm;
    rec_next.overflow_guard   = 1'b0;
    if (sum_is_zero) begin
      rec_next.norm_sum = '0;
      rec_next.exp      = '0;
    end else if (i_rec.sum[`FP_SUM_W-1]) begin
      // Carry out, one step right
      rec_next.norm_sum       = i_rec.sum >> 1;
      rec_next.exp            = exp_in + 10'sd1;
      rec_next.overflow_guard = i_rec.sum[0];
    end else begin
      // Cancellation, may drive the exponent to zero or below
      rec_next.norm_sum = i_rec.sum << norm_shift;
      rec_next.exp      = exp_in - $signed({{(`FP_EXPX_W-`FP_LZC_W){1'b0}}, norm_shift});
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_rec <= rec_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/fp_add_align_sum.sv */
`default_nettype none

`include "fp_add_defines.svh"

module fp_add_align_sum
  import fp_add_stage_pkg::*;
(
  input  wire logic       i_clk,
  input  wire logic       i_rst,
  input  wire logic       i_valid,
  input  wire align_rec_t i_rec,
  output logic            o_valid,
  output sum_rec_t        o_rec
);

  // ========================================================================
  // Alignment of the smaller mantissa
  // ========================================================================

  logic [`FP_ALIGN_W-1:0] ext_large;
  logic [`FP_ALIGN_W-1:0] ext_small;
  logic [`FP_ALIGN_W-1:0] aligned_small;
  logic                   shift_out;
  logic                   sticky;
  sum_rec_t               rec_next;

  // Mantissas placed in the upper half, lower half catches shifted bits
  assign ext_large = {i_rec.mant_large, {`FP_MANT_W{1'b0}}};
  assign ext_small = {i_rec.mant_small, {`FP_MANT_W{1'b0}}};
  // Whole mantissa falls off the bottom
  assign shift_out = (i_rec.shift_amt >= `FP_ALIGN_W);

  always_comb begin
    if (shift_out) begin
      aligned_small = '0;
      sticky        = |ext_small;
    end else begin
      aligned_small = ext_small >> i_rec.shift_amt;
      // Mask keeps only the bits that the shift discards
      sticky = |(ext_small & ~({`FP_ALIGN_W{1'b1}} << i_rec.shift_amt));
    end
  end

  // Magnitude add or subtract, larger minus smaller never goes negative
  always_comb begin
    rec_next.result_sign      = i_rec.sign_large;
    rec_next.both_signs_equal = (i_rec.sign_large == i_rec.sign_small);
    rec_next.exp              = {{(`FP_EXPX_W-`FP_EXP_W){1'b0}}, i_rec.exp_large};
    rec_next.sum              = i_rec.eff_sub ? ({1'b0, ext_large} - {1'b0, aligned_small})
                                              : ({1'b0, ext_large} + {1'b0, aligned_small});
    rec_next.sticky           = sticky;
    rec_next.special          = i_rec.special;
    rec_next.rm               = i_rec.rm;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_rec <= rec_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/fp_add_unpack.sv */
`default_nettype none

`include "fp_add_defines.svh"

module fp_add_unpack
  import fp_format_pkg::*;
  import fp_add_stage_pkg::*;
(
  input  wire logic     i_clk,
  input  wire logic     i_rst,
  input  wire logic     i_valid,
  input  wire fp_word_t i_operand_a,
  input  wire fp_word_t i_operand_b,
  input  wire logic     i_is_subtract,
  input  wire fp_rm_e   i_rounding_mode,
  output logic          o_valid,
  output align_rec_t    o_rec
);

  // ========================================================================
  // Field split and classification
  // ========================================================================

  logic                  sign_a, sign_b;
  logic                  exp_zero_a, exp_zero_b;
  logic                  frac_nz_a, frac_nz_b;
  logic [`FP_EXP_W-1:0]  exp_a, exp_b;
  logic [`FP_MANT_W-1:0] mant_a, mant_b;
  logic                  inf_a, inf_b, nan_a, nan_b, snan_a, snan_b;
  logic                  swap;
  align_rec_t            rec_next;

  assign sign_a     = i_operand_a.sign;
  // Subtraction is addition with B negated
  assign sign_b     = i_operand_b.sign ^ i_is_subtract;
  assign exp_zero_a = (i_operand_a.exponent == '0);
  assign exp_zero_b = (i_operand_b.exponent == '0);
  assign frac_nz_a  = |i_operand_a.fraction;
  assign frac_nz_b  = |i_operand_b.fraction;

  // Subnormals read with exponent 1 and no hidden bit
  assign exp_a  = (exp_zero_a && frac_nz_a) ? {{(`FP_EXP_W-1){1'b0}}, 1'b1}
                                            : i_operand_a.exponent;
  assign exp_b  = (exp_zero_b && frac_nz_b) ? {{(`FP_EXP_W-1){1'b0}}, 1'b1}
                                            : i_operand_b.exponent;
  assign mant_a = {~exp_zero_a, i_operand_a.fraction};
  assign mant_b = {~exp_zero_b, i_operand_b.fraction};

  assign inf_a  = (i_operand_a.exponent == `FP_EXP_MAX) && !frac_nz_a;
  assign inf_b  = (i_operand_b.exponent == `FP_EXP_MAX) && !frac_nz_b;
  assign nan_a  = (i_operand_a.exponent == `FP_EXP_MAX) && frac_nz_a;
  assign nan_b  = (i_operand_b.exponent == `FP_EXP_MAX) && frac_nz_b;
  // Quiet bit clear marks a signalling NaN
  assign snan_a = nan_a && !i_operand_a.fraction[`FP_FRAC_W-1];
  assign snan_b = nan_b && !i_operand_b.fraction[`FP_FRAC_W-1];

  // B is larger on a bigger exponent, or equal exponent and bigger mantissa
  assign swap = (exp_b > exp_a) || ((exp_b == exp_a) && (mant_b > mant_a));

  // ========================================================================
  // Ordered operands and special result
  // ========================================================================

  always_comb begin
    rec_next.sign_large = swap ? sign_b : sign_a;
    rec_next.sign_small = swap ? sign_a : sign_b;
    rec_next.exp_large  = swap ? exp_b : exp_a;
    rec_next.shift_amt  = swap ? (exp_b - exp_a) : (exp_a - exp_b);
    rec_next.mant_large = swap ? mant_b : mant_a;
    rec_next.mant_small = swap ? mant_a : mant_b;
    rec_next.eff_sub    = rec_next.sign_large ^ rec_next.sign_small;
    rec_next.rm         = i_rounding_mode;

    // NaN wins, then inf with inf, then a lone inf
    rec_next.special = '0;
    if (nan_a || nan_b) begin
      rec_next.special.valid   = 1'b1;
      rec_next.special.result  = `FP_CANON_NAN;
      rec_next.special.invalid = snan_a | snan_b;
    end else if (inf_a && inf_b) begin
      rec_next.special.valid = 1'b1;
      if (sign_a == sign_b) begin
        rec_next.special.result = {sign_a, `FP_EXP_MAX, {`FP_FRAC_W{1'b0}}};
      end else begin
        // Opposite infinities cancel to an invalid result
        rec_next.special.result  = `FP_CANON_NAN;
        rec_next.special.invalid = 1'b1;
      end
    end else if (inf_a || inf_b) begin
      rec_next.special.valid  = 1'b1;
      rec_next.special.result = {(inf_a ? sign_a : sign_b), `FP_EXP_MAX, {`FP_FRAC_W{1'b0}}};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_rec <= rec_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/fp_add_stage_pkg.sv */
`default_nettype none

`include "fp_add_defines.svh"

// ==========================================================================
// Records carried between the adder pipeline stages
// ==========================================================================

package fp_add_stage_pkg;
  import fp_format_pkg::*;

  // Unpack -> align/sum
  // Operands already ordered by magnitude
  typedef struct packed {
    logic                  sign_large;
    logic                  sign_small;
    logic [`FP_EXP_W-1:0]  exp_large;
    // Absolute exponent difference
    logic [`FP_EXP_W-1:0]  shift_amt;
    logic [`FP_MANT_W-1:0] mant_large;
    logic [`FP_MANT_W-1:0] mant_small;
    logic                  eff_sub;
    fp_special_t           special;
    fp_rm_e                rm;
  } align_rec_t;

  // Align/sum -> normalize
  typedef struct packed {
    logic                  result_sign;
    // Effective signs agree, picks the sign of an exact zero
    logic                  both_signs_equal;
    logic [`FP_EXPX_W-1:0] exp;
    logic [`FP_SUM_W-1:0]  sum;
    logic                  sticky;
    fp_special_t           special;
    fp_rm_e                rm;
  } sum_rec_t;

  // Normalize -> round
  // Hidden bit of norm_sum sits at FP_SUM_W-2
  typedef struct packed {
    logic                         result_sign;
    logic                         both_signs_equal;
    logic signed [`FP_EXPX_W-1:0] exp;
    logic [`FP_SUM_W-1:0]         norm_sum;
    // Bit lost by the carry right shift
    logic                         overflow_guard;
    logic                         sum_is_zero;
    logic                         sticky;
    fp_special_t                  special;
    fp_rm_e                       rm;
  } norm_rec_t;

endpackage

`default_nettype wire

/* hdl/fp_format_pkg.sv */
`default_nettype none

`include "fp_add_defines.svh"

// ==========================================================================
// Single-precision number format
// ==========================================================================

package fp_format_pkg;

  // IEEE 754 binary32 word, sign in the top bit
  typedef struct packed {
    logic                  sign;
    logic [`FP_EXP_W-1:0]  exponent;
    logic [`FP_FRAC_W-1:0] fraction;
  } fp_word_t;

  // RISC-V fflags order, dz never set by an adder
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

  // RISC-V frm encoding
  // Reserved codes are treated as RNE downstream
  typedef enum logic [2:0] {
    FRM_RNE = 3'd0,
    FRM_RTZ = 3'd1,
    FRM_RDN = 3'd2,
    FRM_RUP = 3'd3,
    FRM_RMM = 3'd4
  } fp_rm_e;

  // Early result for NaN and infinity operands
  typedef struct packed {
    logic     valid;
    fp_word_t result;
    logic     invalid;
  } fp_special_t;

endpackage

`default_nettype wire

/* hdl/fp_add_defines.svh */
`ifndef FP_ADD_DEFINES_SVH
`define FP_ADD_DEFINES_SVH

// ==========================================================================
// Single-precision field widths
// ==========================================================================

`define FP_EXP_W 8
`define FP_FRAC_W 23
// Mantissa including the hidden bit
`define FP_MANT_W 24
// Mantissa extended by its own width for alignment
`define FP_ALIGN_W 48
// Aligned width plus one carry bit
`define FP_SUM_W 49
// Leading-zero count, wide enough for 0..49
`define FP_LZC_W 6
// Signed exponent with headroom for carry and deep cancellation
`define FP_EXPX_W 10

// Special bit patterns
`define FP_EXP_MAX 8'd255
`define FP_CANON_NAN 32'h7FC00000

// Pipeline depth from input strobe to output strobe
`define FP_ADD_LATENCY 4

`endif
